/* hdl/cpu_pkg.sv */
package cpu_pkg;

	typedef enum logic [3:0] {
		T_INH    = 4'h0,
		T_CMP    = 4'h3,
		T_MOV    = 4'h4,
		T_ALU    = 4'h7,
		T_LDI    = 4'h8,
		T_LOAD   = 4'h9,
		T_STORE  = 4'ha,
		T_BRANCH = 4'hb
	} iclass_t;

	// inherent-class opcodes
	localparam logic [3:0] OP_NOP  = 4'h0;
	localparam logic [3:0] OP_HALT = 4'h4;

	typedef struct packed {
		iclass_t     iclass;
		logic [3:0]  op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [10:0] spare;
		logic        size;
	} instr_reg_t;

	typedef struct packed {
		iclass_t     iclass;
		logic [3:0]  op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [14:0] uval;
		logic        size;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t imm;
	} instr_t;

	typedef enum logic [4:0] {
		S_RESET, S_FETCH, S_FETCH2, S_EVAL,
		S_INH, S_CMP, S_CMP2, S_MOV,
		S_ALU, S_ALU2, S_ALU3, S_ALU4, S_MDR2RA,
		S_LDIU, S_BRANCH,
		S_LOAD, S_LOAD2, S_LOAD3, S_LOADD2, S_LOADD3,
		S_STORE, S_STORE2, S_STORE3, S_STORE4, S_STORE5,
		S_TERM, S_HALT
	} state_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_LSHIFT, ALU_RSHIFTA, ALU_RSHIFTL
	} alu_func_t;

	typedef enum logic [1:0] {ALU_B, ALU_4, ALU_SVAL} alu_in_t;
	typedef enum logic [1:0] {REG_ALU, REG_B, REG_MDR, REG_UVAL} reg_in_t;
	typedef enum logic [1:0] {MDR_MDR, MDR_DBUS, MDR_ALU, MDR_A} mdr_in_t;
	typedef enum logic [1:0] {MAR_MAR, MAR_ALU} mar_t;
	typedef enum logic [1:0] {PC_PC, PC_NEXT, PC_REL} pc_t;
	typedef enum logic [1:0] {CCR_CCR, CCR_ALU} ccr_sel_t;

	typedef enum logic [1:0] {
		REG_WRITE_NONE = 2'd0,
		REG_WRITE_LO   = 2'd1,
		REG_WRITE_HI   = 2'd2,
		REG_WRITE_DW   = 2'd3
	} reg_write_t;

	typedef logic [3:0] byte_en_t;
	localparam byte_en_t BE_ALL = 4'hf;

	typedef enum logic [1:0] {SZ_WORD, SZ_HALF, SZ_BYTE} access_size_t;

	typedef logic [3:0] reg_addr_t;

endpackage

/* hdl/branch_cond.sv */
module branch_cond (
	input  logic [3:0] op,
	input  logic [2:0] ccr,
	output logic       taken
);
	logic ltu;
	logic lt;
	logic eq;

	assign {ltu, lt, eq} = ccr;

	always_comb
		case (op)
			4'h0:    taken = 1'b1; // bra
			4'h1:    taken = eq;
			4'h2:    taken = ~eq;
			4'h3:    taken = ~(ltu | eq); // bgtu
			4'h4:    taken = ~(lt | eq);
			4'h5:    taken = ~lt;
			4'h6:    taken = lt | eq;
			4'h7:    taken = lt;
			4'h8:    taken = ~ltu; // bgeu
			4'h9:    taken = ltu;
			4'ha:    taken = ltu | eq;
			default: taken = 1'b0; // never
		endcase

endmodule

/* hdl/bus_cycle.sv */
module bus_cycle (
	input  logic clk_i,
	input  logic rst_i,
	input  logic start,
	input  logic write,
	input  logic ack,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic done
);

	// stray ack outside a cycle never counts
	assign done = cyc & ack;

	always_ff @(posedge clk_i or posedge rst_i)
		if (rst_i)
		begin
			cyc <= 1'b0;
			stb <= 1'b0;
			we <= 1'b0;
		end
		else if (start)
		begin
			cyc <= 1'b1;
			stb <= 1'b1;
			we <= write;
		end
		else
		begin
			stb <= 1'b0; // single-cycle strobe
			if (done)
			begin
				cyc <= 1'b0;
				we <= 1'b0;
			end
		end

endmodule

/* hdl/lane_enable.sv */
module lane_enable (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   load,
	input  cpu_pkg::access_size_t  size,
	input  logic [1:0]             align,
	output cpu_pkg::byte_en_t      byteenable
);

	always_ff @(posedge clk_i or posedge rst_i)
		if (rst_i)
			byteenable <= cpu_pkg::BE_ALL;
		else if (load)
			case (size)
				cpu_pkg::SZ_HALF:
					byteenable <= align[1] ? 4'b0011 : 4'b1100; // big-endian halves
				cpu_pkg::SZ_BYTE:
					byteenable <= 4'b1000 >> align;
				default:
					byteenable <= cpu_pkg::BE_ALL;
			endcase

endmodule

/* hdl/datapath_decode.sv */
module datapath_decode (
	input  cpu_pkg::state_t      state,
	input  cpu_pkg::instr_t      ir,
	input  logic                 taken,
	input  logic                 ins_done,
	output logic                 ir_write,
	output cpu_pkg::ccr_sel_t    ccrsel,
	output cpu_pkg::alu_func_t   alu_func,
	output cpu_pkg::alu_in_t     alu2sel,
	output cpu_pkg::reg_in_t     regsel,
	output cpu_pkg::reg_addr_t   reg_read_addr1,
	output cpu_pkg::reg_addr_t   reg_read_addr2,
	output cpu_pkg::reg_addr_t   reg_write_addr,
	output cpu_pkg::reg_write_t  reg_write,
	output logic                 a_write,
	output logic                 b_write,
	output cpu_pkg::mdr_in_t     mdrsel,
	output cpu_pkg::mar_t        marsel,
	output cpu_pkg::pc_t         pcsel
);

	always_comb
	begin
		ir_write = 1'b0;
		ccrsel = cpu_pkg::CCR_CCR;
		alu_func = cpu_pkg::ALU_ADD;
		alu2sel = cpu_pkg::ALU_B;
		regsel = cpu_pkg::REG_ALU;
		reg_read_addr1 = ir.r.ra;
		reg_read_addr2 = ir.r.rb;
		reg_write_addr = ir.r.ra;
		reg_write = cpu_pkg::REG_WRITE_NONE;
		a_write = 1'b0;
		b_write = 1'b0;
		mdrsel = cpu_pkg::MDR_MDR;
		marsel = cpu_pkg::MAR_MAR;
		pcsel = cpu_pkg::PC_PC;

		case (state)
			cpu_pkg::S_FETCH:
				ir_write = 1'b1;
			cpu_pkg::S_FETCH2:
			begin
				ir_write = 1'b1; // IR follows the bus until ack
				if (ins_done)
					pcsel = cpu_pkg::PC_NEXT;
			end
			cpu_pkg::S_EVAL:
			begin
				a_write = 1'b1; // A <= rA
				b_write = 1'b1; // B <= rB
			end
			cpu_pkg::S_CMP:
				alu_func = cpu_pkg::ALU_SUB;
			cpu_pkg::S_CMP2:
			begin
				alu_func = cpu_pkg::ALU_SUB; // hold operands for the flags
				ccrsel = cpu_pkg::CCR_ALU;
			end
			cpu_pkg::S_MOV:
			begin
				regsel = cpu_pkg::REG_B;
				reg_write = cpu_pkg::reg_write_t'(ir.r.op[1:0]);
			end
			cpu_pkg::S_ALU:
			begin
				reg_read_addr1 = ir.r.rb;
				reg_read_addr2 = ir.r.rc;
				a_write = 1'b1;
				b_write = 1'b1;
			end
			cpu_pkg::S_ALU2:
				alu_func = cpu_pkg::alu_func_t'(ir.r.op[2:0]);
			cpu_pkg::S_ALU3:
			begin
				alu_func = cpu_pkg::alu_func_t'(ir.r.op[2:0]);
				alu2sel = cpu_pkg::ALU_SVAL;
			end
			cpu_pkg::S_ALU4:
				mdrsel = cpu_pkg::MDR_ALU;
			cpu_pkg::S_MDR2RA:
			begin
				regsel = cpu_pkg::REG_MDR;
				reg_write = cpu_pkg::REG_WRITE_DW;
			end
			cpu_pkg::S_LDIU:
			begin
				regsel = cpu_pkg::REG_UVAL;
				reg_write = cpu_pkg::REG_WRITE_DW;
			end
			cpu_pkg::S_BRANCH:
				if (taken)
					pcsel = cpu_pkg::PC_REL;
			cpu_pkg::S_LOAD,
			cpu_pkg::S_STORE:
			begin
				reg_read_addr1 = ir.r.rb; // base register
				a_write = 1'b1;
			end
			cpu_pkg::S_LOAD2:
				alu2sel = cpu_pkg::ALU_SVAL;
			cpu_pkg::S_STORE2:
			begin
				alu2sel = cpu_pkg::ALU_SVAL;
				a_write = 1'b1; // A <= rA, store data
			end
			cpu_pkg::S_LOAD3:
				marsel = cpu_pkg::MAR_ALU;
			cpu_pkg::S_STORE3:
			begin
				marsel = cpu_pkg::MAR_ALU;
				mdrsel = cpu_pkg::MDR_A;
			end
			cpu_pkg::S_LOADD2,
			cpu_pkg::S_LOADD3:
				mdrsel = cpu_pkg::MDR_DBUS;
			default:
				pcsel = cpu_pkg::PC_PC;
		endcase
	end

endmodule

/* hdl/control_fsm.sv */
module control_fsm (
	input  logic             clk_i,
	input  logic             rst_i,
	input  cpu_pkg::instr_t  ir,
	input  logic             ins_done,
	input  logic             dat_done,
	output cpu_pkg::state_t  state,
	output logic             ins_start,
	output logic             dat_start,
	output logic             dat_write,
	output logic             lane_load,
	output logic             halt
);
	cpu_pkg::state_t state_next;

	always_ff @(posedge clk_i or posedge rst_i)
		if (rst_i)
			state <= cpu_pkg::S_RESET;
		else
			state <= state_next;

	assign ins_start = (state == cpu_pkg::S_FETCH);
	assign dat_start = (state == cpu_pkg::S_LOADD2) || (state == cpu_pkg::S_STORE4);
	assign dat_write = (state == cpu_pkg::S_STORE4);
	assign lane_load = dat_start; // mask lands with cyc
	assign halt = (state == cpu_pkg::S_HALT);

	always_comb
	begin
		state_next = state;
		case (state)
			cpu_pkg::S_RESET:
				state_next = cpu_pkg::S_FETCH;
			cpu_pkg::S_FETCH:
				state_next = cpu_pkg::S_FETCH2;
			cpu_pkg::S_FETCH2:
				if (ins_done)
					state_next = cpu_pkg::S_EVAL;
			cpu_pkg::S_EVAL:
				if (ir.r.size)
					state_next = cpu_pkg::S_HALT; // long form not supported
				else
					case (ir.r.iclass)
						cpu_pkg::T_INH:    state_next = cpu_pkg::S_INH;
						cpu_pkg::T_CMP:    state_next = cpu_pkg::S_CMP;
						cpu_pkg::T_MOV:    state_next = cpu_pkg::S_MOV;
						cpu_pkg::T_ALU:    state_next = cpu_pkg::S_ALU;
						cpu_pkg::T_LDI:    state_next = cpu_pkg::S_LDIU;
						cpu_pkg::T_LOAD:   state_next = cpu_pkg::S_LOAD;
						cpu_pkg::T_STORE:  state_next = cpu_pkg::S_STORE;
						cpu_pkg::T_BRANCH: state_next = cpu_pkg::S_BRANCH;
						default:           state_next = cpu_pkg::S_HALT; // illegal class
					endcase
			cpu_pkg::S_INH:
				case (ir.r.op)
					cpu_pkg::OP_NOP:  state_next = cpu_pkg::S_FETCH;
					cpu_pkg::OP_HALT: state_next = cpu_pkg::S_HALT;
					default:          state_next = cpu_pkg::S_HALT; // illegal op
				endcase
			cpu_pkg::S_CMP:
				state_next = cpu_pkg::S_CMP2;
			cpu_pkg::S_ALU:
				state_next = ir.r.op[3] ? cpu_pkg::S_ALU3 : cpu_pkg::S_ALU2;
			cpu_pkg::S_ALU2,
			cpu_pkg::S_ALU3:
				state_next = cpu_pkg::S_ALU4;
			cpu_pkg::S_ALU4:
				state_next = cpu_pkg::S_MDR2RA;
			cpu_pkg::S_LOAD:
				state_next = cpu_pkg::S_LOAD2;
			cpu_pkg::S_LOAD2:
				state_next = cpu_pkg::S_LOAD3;
			cpu_pkg::S_LOAD3:
				state_next = cpu_pkg::S_LOADD2;
			cpu_pkg::S_LOADD2:
				state_next = cpu_pkg::S_LOADD3;
			cpu_pkg::S_LOADD3:
				if (dat_done)
					state_next = cpu_pkg::S_MDR2RA;
			cpu_pkg::S_STORE:
				state_next = cpu_pkg::S_STORE2;
			cpu_pkg::S_STORE2:
				state_next = cpu_pkg::S_STORE3;
			cpu_pkg::S_STORE3:
				state_next = cpu_pkg::S_STORE4;
			cpu_pkg::S_STORE4:
				state_next = cpu_pkg::S_STORE5;
			cpu_pkg::S_STORE5:
				if (dat_done)
					state_next = cpu_pkg::S_TERM;
			cpu_pkg::S_CMP2,
			cpu_pkg::S_MOV,
			cpu_pkg::S_MDR2RA,
			cpu_pkg::S_LDIU,
			cpu_pkg::S_BRANCH,
			cpu_pkg::S_TERM:
				state_next = cpu_pkg::S_FETCH;
			cpu_pkg::S_HALT:
				state_next = cpu_pkg::S_HALT; // only reset leaves
			default:
				state_next = cpu_pkg::S_HALT;
		endcase
	end

endmodule

/* hdl/cpu_control.sv */
module cpu_control (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  cpu_pkg::instr_t       ir,
	input  logic [2:0]            ccr,
	input  logic                  insbus_ack,
	input  logic                  datbus_ack,
	input  logic [1:0]            datbus_align,
	output logic                  ir_write,
	output cpu_pkg::ccr_sel_t     ccrsel,
	output cpu_pkg::alu_func_t    alu_func,
	output cpu_pkg::alu_in_t      alu2sel,
	output cpu_pkg::reg_in_t      regsel,
	output cpu_pkg::reg_addr_t    reg_read_addr1,
	output cpu_pkg::reg_addr_t    reg_read_addr2,
	output cpu_pkg::reg_addr_t    reg_write_addr,
	output cpu_pkg::reg_write_t   reg_write,
	output logic                  a_write,
	output logic                  b_write,
	output cpu_pkg::mdr_in_t      mdrsel,
	output cpu_pkg::mar_t         marsel,
	output cpu_pkg::pc_t          pcsel,
	output logic                  insbus_cyc,
	output logic                  insbus_stb,
	output logic                  datbus_cyc,
	output logic                  datbus_stb,
	output logic                  datbus_write,
	output cpu_pkg::byte_en_t     byteenable,
	output logic                  halt
);
	cpu_pkg::state_t state;
	logic ins_start, ins_done;
	logic dat_start, dat_done, dat_write;
	logic lane_load;
	logic taken;

	control_fsm u_control_fsm (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.ir        (ir),
		.ins_done  (ins_done),
		.dat_done  (dat_done),
		.state     (state),
		.ins_start (ins_start),
		.dat_start (dat_start),
		.dat_write (dat_write),
		.lane_load (lane_load),
		.halt      (halt)
	);

	datapath_decode u_datapath_decode (
		.state          (state),
		.ir             (ir),
		.taken          (taken),
		.ins_done       (ins_done),
		.ir_write       (ir_write),
		.ccrsel         (ccrsel),
		.alu_func       (alu_func),
		.alu2sel        (alu2sel),
		.regsel         (regsel),
		.reg_read_addr1 (reg_read_addr1),
		.reg_read_addr2 (reg_read_addr2),
		.reg_write_addr (reg_write_addr),
		.reg_write      (reg_write),
		.a_write        (a_write),
		.b_write        (b_write),
		.mdrsel         (mdrsel),
		.marsel         (marsel),
		.pcsel          (pcsel)
	);

	branch_cond u_branch_cond (
		.op    (ir.r.op),
		.ccr   (ccr),
		.taken (taken)
	);

	lane_enable u_lane_enable (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.load       (lane_load),
		.size       (cpu_pkg::access_size_t'(ir.imm.op[1:0])),
		.align      (datbus_align),
		.byteenable (byteenable)
	);

	bus_cycle u_ins_bus (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.start (ins_start),
		.write (1'b0), // fetch only reads
		.ack   (insbus_ack),
		.cyc   (insbus_cyc),
		.stb   (insbus_stb),
		.we    (),
		.done  (ins_done)
	);

	bus_cycle u_dat_bus (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.start (dat_start),
		.write (dat_write),
		.ack   (datbus_ack),
		.cyc   (datbus_cyc),
		.stb   (datbus_stb),
		.we    (datbus_write),
		.done  (dat_done)
	);

endmodule

/* bench/cpu_control_sva.sv */
module cpu_control_sva (
	input logic clk_i,
	input logic rst_i,
	input logic insbus_cyc,
	input logic insbus_stb,
	input logic datbus_cyc,
	input logic datbus_stb,
	input logic halt
);
	timeunit 1ns;
	timeprecision 100ps;

	ins_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		insbus_stb |-> insbus_cyc)
		else $error("insbus_stb high without insbus_cyc");

	dat_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		datbus_stb |-> datbus_cyc)
		else $error("datbus_stb high without datbus_cyc");

	ins_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
		insbus_stb |=> !insbus_stb)
		else $error("insbus_stb longer than one cycle");

	dat_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
		datbus_stb |=> !datbus_stb)
		else $error("datbus_stb longer than one cycle");

	// only reset leaves halt
	halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
		halt |=> halt && !insbus_cyc && !datbus_cyc)
		else $error("halt dropped or bus cycle started while halted");

endmodule

bind cpu_control cpu_control_sva u_cpu_control_sva (
	.clk_i      (clk_i),
	.rst_i      (rst_i),
	.insbus_cyc (insbus_cyc),
	.insbus_stb (insbus_stb),
	.datbus_cyc (datbus_cyc),
	.datbus_stb (datbus_stb),
	.halt       (halt)
);

/* bench/tb_cpu_control.sv */
module tb_cpu_control;
	timeunit 1ns;
	timeprecision 100ps;

	logic                 clk_i;
	logic                 rst_i;
	cpu_pkg::instr_t      ir;
	logic [2:0]           ccr;
	logic                 insbus_ack;
	logic                 datbus_ack;
	logic [1:0]           datbus_align;
	logic                 ir_write;
	cpu_pkg::ccr_sel_t    ccrsel;
	cpu_pkg::alu_func_t   alu_func;
	cpu_pkg::alu_in_t     alu2sel;
	cpu_pkg::reg_in_t     regsel;
	cpu_pkg::reg_addr_t   reg_read_addr1;
	cpu_pkg::reg_addr_t   reg_read_addr2;
	cpu_pkg::reg_addr_t   reg_write_addr;
	cpu_pkg::reg_write_t  reg_write;
	logic                 a_write;
	logic                 b_write;
	cpu_pkg::mdr_in_t     mdrsel;
	cpu_pkg::mar_t        marsel;
	cpu_pkg::pc_t         pcsel;
	logic                 insbus_cyc;
	logic                 insbus_stb;
	logic                 datbus_cyc;
	logic                 datbus_stb;
	logic                 datbus_write;
	cpu_pkg::byte_en_t    byteenable;
	logic                 halt;

	int seed = 18;

	cpu_control u_cpu_control (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.ir             (ir),
		.ccr            (ccr),
		.insbus_ack     (insbus_ack),
		.datbus_ack     (datbus_ack),
		.datbus_align   (datbus_align),
		.ir_write       (ir_write),
		.ccrsel         (ccrsel),
		.alu_func       (alu_func),
		.alu2sel        (alu2sel),
		.regsel         (regsel),
		.reg_read_addr1 (reg_read_addr1),
		.reg_read_addr2 (reg_read_addr2),
		.reg_write_addr (reg_write_addr),
		.reg_write      (reg_write),
		.a_write        (a_write),
		.b_write        (b_write),
		.mdrsel         (mdrsel),
		.marsel         (marsel),
		.pcsel          (pcsel),
		.insbus_cyc     (insbus_cyc),
		.insbus_stb     (insbus_stb),
		.datbus_cyc     (datbus_cyc),
		.datbus_stb     (datbus_stb),
		.datbus_write   (datbus_write),
		.byteenable     (byteenable),
		.halt           (halt)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	task automatic abort_run;
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic fail_timeout(input string what);
		$display("TIMEOUT at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_pc(input string name, input cpu_pkg::pc_t got, input cpu_pkg::pc_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_alu(input string name, input cpu_pkg::alu_func_t got,
		input cpu_pkg::alu_func_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_opnd(input string name, input cpu_pkg::alu_in_t got,
		input cpu_pkg::alu_in_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_src(input string name, input cpu_pkg::reg_in_t got,
		input cpu_pkg::reg_in_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_ccr(input string name, input cpu_pkg::ccr_sel_t got,
		input cpu_pkg::ccr_sel_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_mdr(input string name, input cpu_pkg::mdr_in_t got,
		input cpu_pkg::mdr_in_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_mar(input string name, input cpu_pkg::mar_t got,
		input cpu_pkg::mar_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_wr(input string name, input cpu_pkg::reg_write_t got,
		input cpu_pkg::reg_write_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_addr(input string name, input cpu_pkg::reg_addr_t got,
		input cpu_pkg::reg_addr_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_be(input string name, input cpu_pkg::byte_en_t got,
		input cpu_pkg::byte_en_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	// lands 1 ns after the rising edge
	task automatic cycle;
		@(posedge clk_i);
		#1;
	endtask

	function automatic logic [3:0] rand_nib;
		logic [31:0] r;
		r = $random(seed);
		rand_nib = r[3:0];
	endfunction

	function automatic cpu_pkg::instr_t make_instr(input cpu_pkg::iclass_t c,
		input logic [3:0] op, input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc);
		cpu_pkg::instr_t w;
		w = '0;
		w.r.iclass = c;
		w.r.op = op;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.rc = rc;
		return w;
	endfunction

	// ccr is {ltu, lt, eq}
	function automatic logic branch_expect(input logic [3:0] op, input logic [2:0] c);
		logic ltu;
		logic lt;
		logic eq;
		ltu = c[2];
		lt = c[1];
		eq = c[0];
		case (op)
			4'd0:    branch_expect = 1'b1;
			4'd1:    branch_expect = eq;
			4'd2:    branch_expect = !eq;
			4'd3:    branch_expect = !ltu && !eq;
			4'd4:    branch_expect = !lt && !eq;
			4'd5:    branch_expect = !lt;
			4'd6:    branch_expect = lt || eq;
			4'd7:    branch_expect = lt;
			4'd8:    branch_expect = !ltu;
			4'd9:    branch_expect = ltu;
			4'd10:   branch_expect = ltu || eq;
			default: branch_expect = 1'b0;
		endcase
	endfunction

	function automatic cpu_pkg::byte_en_t lane_mask(input logic [1:0] size, input logic [1:0] align);
		case (size)
			2'd1:    lane_mask = (align < 2'd2) ? 4'b1100 : 4'b0011; // upper half at address 0
			2'd2:    lane_mask = 4'b0001 << (2'd3 - align); // lane 3 is address 0
			default: lane_mask = cpu_pkg::BE_ALL;
		endcase
	endfunction

	task automatic apply_reset;
		rst_i = 1'b1;
		repeat (4) cycle();
		rst_i = 1'b0;
		#4;
		check_bit("insbus_cyc", insbus_cyc, 1'b0);
		check_bit("insbus_stb", insbus_stb, 1'b0);
		check_bit("datbus_cyc", datbus_cyc, 1'b0);
		check_bit("datbus_stb", datbus_stb, 1'b0);
		check_bit("datbus_write", datbus_write, 1'b0);
		check_be("byteenable", byteenable, cpu_pkg::BE_ALL);
		check_bit("halt", halt, 1'b0);
		check_wr("reg_write", reg_write, cpu_pkg::REG_WRITE_NONE);
		check_bit("ir_write", ir_write, 1'b0);
	endtask

	// returns in the S_EVAL cycle
	task automatic fetch_instr(input cpu_pkg::instr_t instr);
		int n;
		int dly;
		n = 0;
		while (!insbus_cyc)
		begin
			if (n == 50)
				fail_timeout("instruction bus cycle never started");
			cycle();
			n++;
		end
		check_bit("insbus_stb", insbus_stb, 1'b1);
		ir = instr;
		dly = {$random(seed)} % 4;
		repeat (dly)
		begin
			#4;
			check_bit("ir_write", ir_write, 1'b1);
			check_pc("pcsel", pcsel, cpu_pkg::PC_PC);
			cycle();
			check_bit("insbus_stb", insbus_stb, 1'b0);
			check_bit("insbus_cyc", insbus_cyc, 1'b1);
		end
		insbus_ack = 1'b1;
		#4;
		check_bit("ir_write", ir_write, 1'b1);
		check_pc("pcsel", pcsel, cpu_pkg::PC_NEXT);
		cycle();
		insbus_ack = 1'b0;
		check_bit("insbus_cyc", insbus_cyc, 1'b0);
	endtask

	task automatic test_reset_fetch;
		apply_reset();
		cycle();
		check_bit("ir_write", ir_write, 1'b1); // S_FETCH
		check_bit("insbus_cyc", insbus_cyc, 1'b0);
		cycle();
		check_bit("insbus_cyc", insbus_cyc, 1'b1);
		check_bit("insbus_stb", insbus_stb, 1'b1);
		fetch_instr(make_instr(cpu_pkg::T_INH, cpu_pkg::OP_NOP, 4'h0, 4'h0, 4'h0));
		cycle();
		cycle();
		check_bit("ir_write", ir_write, 1'b1);
	endtask

	task automatic test_alu;
		logic [3:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		repeat (8)
		begin
			op = rand_nib();
			ra = rand_nib();
			rb = rand_nib();
			rc = rand_nib();
			fetch_instr(make_instr(cpu_pkg::T_ALU, op, ra, rb, rc));
			cycle();
			#4;
			check_addr("reg_read_addr1", reg_read_addr1, rb);
			check_addr("reg_read_addr2", reg_read_addr2, rc);
			check_bit("a_write", a_write, 1'b1);
			check_bit("b_write", b_write, 1'b1);
			cycle();
			#4;
			check_alu("alu_func", alu_func, cpu_pkg::alu_func_t'(op[2:0]));
			check_opnd("alu2sel", alu2sel, op[3] ? cpu_pkg::ALU_SVAL : cpu_pkg::ALU_B);
			cycle();
			#4;
			check_mdr("mdrsel", mdrsel, cpu_pkg::MDR_ALU); // result parked in MDR
			cycle();
			#4;
			check_wr("reg_write", reg_write, cpu_pkg::REG_WRITE_DW);
			check_src("regsel", regsel, cpu_pkg::REG_MDR);
			check_addr("reg_write_addr", reg_write_addr, ra);
			cycle();
			check_bit("ir_write", ir_write, 1'b1); // back in fetch after 5
		end
	endtask

	task automatic test_compare;
		logic [3:0] ra;
		ra = rand_nib();
		fetch_instr(make_instr(cpu_pkg::T_CMP, 4'h0, ra, rand_nib(), 4'h0));
		cycle();
		cycle();
		#4;
		check_alu("alu_func", alu_func, cpu_pkg::ALU_SUB);
		check_ccr("ccrsel", ccrsel, cpu_pkg::CCR_ALU);
		cycle();
		check_bit("ir_write", ir_write, 1'b1);
		fetch_instr(make_instr(cpu_pkg::T_LDI, 4'h0, ra, 4'h0, rand_nib()));
		cycle();
		#4;
		check_src("regsel", regsel, cpu_pkg::REG_UVAL);
		check_wr("reg_write", reg_write, cpu_pkg::REG_WRITE_DW);
		check_addr("reg_write_addr", reg_write_addr, ra);
		cycle();
		check_bit("ir_write", ir_write, 1'b1);
	endtask

	task automatic test_branches;
		for (int op = 0; op < 16; op++)
			for (int c = 0; c < 8; c++)
			begin
				ccr = c[2:0];
				fetch_instr(make_instr(cpu_pkg::T_BRANCH, op[3:0], 4'h0, 4'h0, 4'h0));
				cycle();
				#4;
				check_pc("pcsel", pcsel,
					branch_expect(op[3:0], c[2:0]) ? cpu_pkg::PC_REL : cpu_pkg::PC_PC);
				cycle();
				check_bit("ir_write", ir_write, 1'b1);
			end
	endtask

	task automatic mem_access(input logic store, input logic [1:0] size, input logic [1:0] align);
		int n;
		int dly;
		datbus_align = align;
		fetch_instr(make_instr(store ? cpu_pkg::T_STORE : cpu_pkg::T_LOAD, {2'b00, size},
			rand_nib(), rand_nib(), 4'h0));
		n = 0;
		while (!datbus_cyc)
		begin
			if (n == 50)
				fail_timeout("data bus cycle never started");
			cycle();
			n++;
		end
		check_bit("datbus_stb", datbus_stb, 1'b1);
		check_bit("datbus_write", datbus_write, store);
		check_be("byteenable", byteenable, lane_mask(size, align));
		check_mdr("mdrsel", mdrsel, store ? cpu_pkg::MDR_MDR : cpu_pkg::MDR_DBUS);
		check_mar("marsel", marsel, cpu_pkg::MAR_MAR); // address held during the cycle
		dly = {$random(seed)} % 4;
		repeat (dly)
		begin
			cycle();
			check_bit("datbus_cyc", datbus_cyc, 1'b1); // waits for late ack
			check_bit("datbus_stb", datbus_stb, 1'b0);
			check_bit("datbus_write", datbus_write, store);
		end
		datbus_ack = 1'b1;
		cycle();
		datbus_ack = 1'b0;
		check_bit("datbus_cyc", datbus_cyc, 1'b0);
		check_bit("datbus_write", datbus_write, 1'b0);
		#4;
		if (store)
			check_wr("reg_write", reg_write, cpu_pkg::REG_WRITE_NONE);
		else
		begin
			check_wr("reg_write", reg_write, cpu_pkg::REG_WRITE_DW);
			check_src("regsel", regsel, cpu_pkg::REG_MDR);
		end
		cycle();
		check_bit("ir_write", ir_write, 1'b1);
	endtask

	task automatic test_load_store;
		for (int st = 0; st < 2; st++)
			for (int sz = 0; sz < 3; sz++)
				for (int al = 0; al < 4; al++)
					mem_access(st[0], sz[1:0], al[1:0]);
	endtask

	task automatic expect_halt;
		int n;
		n = 0;
		while (!halt)
		begin
			if (n == 50)
				fail_timeout("halt was never raised");
			cycle();
			n++;
		end
		repeat (20)
		begin
			cycle();
			check_bit("halt", halt, 1'b1);
			check_bit("insbus_cyc", insbus_cyc, 1'b0);
			check_bit("datbus_cyc", datbus_cyc, 1'b0);
		end
	endtask

	task automatic test_halt;
		cpu_pkg::instr_t w;
		fetch_instr(make_instr(cpu_pkg::T_INH, cpu_pkg::OP_HALT, 4'h0, 4'h0, 4'h0));
		expect_halt();
		apply_reset();
		fetch_instr(make_instr(cpu_pkg::iclass_t'(4'h1), 4'h0, 4'h0, 4'h0, 4'h0));
		expect_halt();
		apply_reset();
		w = make_instr(cpu_pkg::T_ALU, 4'h0, 4'h1, 4'h2, 4'h3);
		w.r.size = 1'b1; // long form
		fetch_instr(w);
		expect_halt();
	endtask

	initial
	begin
		rst_i = 1'b1;
		ir = '0;
		ccr = 3'b000;
		insbus_ack = 1'b0;
		datbus_ack = 1'b0;
		datbus_align = 2'b00;
		test_reset_fetch();
		test_alu();
		test_compare();
		test_branches();
		test_load_store();
		test_halt();
		$display("Everything OK");
		$finish;
	end

endmodule

/* sim.f */
hdl/cpu_pkg.sv
hdl/branch_cond.sv
hdl/bus_cycle.sv
hdl/lane_enable.sv
hdl/datapath_decode.sv
hdl/control_fsm.sv
hdl/cpu_control.sv
bench/cpu_control_sva.sv
bench/tb_cpu_control.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sim.f --top-module tb_cpu_control -Mdir obj_dir &&
./obj_dir/Vtb_cpu_control || exit 1
